// ==== include/exception_codes.svh ====
`ifndef EXCEPTION_CODES_SVH
`define EXCEPTION_CODES_SVH

// 3-bit exception codes reported by the MMU
`define EXCEPTION_TYPE_NONE     3'd0
`define EXCEPTION_TYPE_TLB_MISS 3'd1 // user access with no matching entry
`define EXCEPTION_TYPE_PRIV     3'd2 // TLB fill attempted in user mode
`define EXCEPTION_TYPE_BUS      3'd3 // physical address outside the RAM

`endif

// ==== hdl/mmu_pkg.sv ====
`include "exception_codes.svh"

package mmu_pkg;

    localparam int addr_bits        = 32;
    localparam int page_offset_bits = 12; // 4 KiB pages
    localparam int vpn_bits         = addr_bits - page_offset_bits;
    localparam int ppn_bits         = addr_bits - page_offset_bits;

    typedef enum logic [1:0] {
        idle,
        lookup,
        bus_cycle,
        respond
    } ctrl_state_t;

    typedef logic [2:0] exc_code_t;

    localparam exc_code_t exc_none     = `EXCEPTION_TYPE_NONE;
    localparam exc_code_t exc_tlb_miss = `EXCEPTION_TYPE_TLB_MISS;
    localparam exc_code_t exc_priv     = `EXCEPTION_TYPE_PRIV;
    localparam exc_code_t exc_bus      = `EXCEPTION_TYPE_BUS;

endpackage

// ==== hdl/tlb_lookup_if.sv ====
`timescale 1ns/1ps

interface tlb_lookup_if;
    import mmu_pkg::*;

    logic [vpn_bits-1:0] lookup_vpn;
    logic                hit;
    logic [ppn_bits-1:0] ppn;

    logic                fill; // one-cycle strobe that the controller qualifies by privilege
    logic [vpn_bits-1:0] fill_vpn;
    logic [ppn_bits-1:0] fill_ppn;

    modport ctrl (
        output lookup_vpn,
        output fill,
        output fill_vpn,
        output fill_ppn,
        input  hit,
        input  ppn
    );

    modport tlb (
        input  lookup_vpn,
        input  fill,
        input  fill_vpn,
        input  fill_ppn,
        output hit,
        output ppn
    );

endinterface

// ==== hdl/tlb.sv ====
`timescale 1ns/1ps

module tlb #(
    parameter int tlb_entries = 4
) (
    input logic       clk,
    input logic       reset,
    tlb_lookup_if.tlb lk
);
    import mmu_pkg::*;

    localparam int ptr_bits = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    logic [tlb_entries-1:0] valid;
    logic [vpn_bits-1:0]    vpn_tab [tlb_entries];
    logic [ppn_bits-1:0]    ppn_tab [tlb_entries];
    logic [ptr_bits-1:0]    replace_ptr;

    // a later matching entry overrides an earlier one
    always_comb begin
        lk.hit = 1'b0;
        lk.ppn = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (valid[i] && (vpn_tab[i] == lk.lookup_vpn)) begin
                lk.hit = 1'b1;
                lk.ppn = ppn_tab[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid       <= '0;
            replace_ptr <= '0;
        end else if (lk.fill) begin
            valid[replace_ptr] <= 1'b1;
            if (replace_ptr == ptr_bits'(tlb_entries - 1)) begin
                replace_ptr <= '0; // wrap for round robin
            end else begin
                replace_ptr <= replace_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill) begin
            vpn_tab[replace_ptr] <= lk.fill_vpn;
            ppn_tab[replace_ptr] <= lk.fill_ppn;
        end
    end

endmodule

// ==== hdl/mmu_control.sv ====
`timescale 1ns/1ps

module mmu_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                supervisor,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [31:0]         adr,
    input  logic [31:0]         dat_w,
    output logic [31:0]         dat_r,
    output logic                ack,
    output logic                err,
    input  logic                tlb_write,
    input  logic [31:0]         tlb_write_vaddr,
    input  logic [31:0]         tlb_write_paddr,
    output logic [31:0]         fault_addr,
    output mmu_pkg::exc_code_t  exception,
    tlb_lookup_if.ctrl          lk,
    output logic                ram_cyc,
    output logic                ram_stb,
    output logic                ram_we,
    output logic [31:0]         ram_adr,
    output logic [31:0]         ram_dat_w,
    input  logic [31:0]         ram_dat_r,
    input  logic                ram_ack,
    input  logic                ram_err
);
    import mmu_pkg::*;

    ctrl_state_t state;
    logic [31:0] req_vaddr;
    logic        req_we;
    logic [31:0] req_dat_w;
    logic        req_super;
    logic        miss_pend;
    logic        translate_ok;
    logic [31:0] phys_addr;

    assign lk.lookup_vpn = req_vaddr[addr_bits-1:page_offset_bits];
    assign lk.fill       = tlb_write && supervisor; // user-mode fills never reach the TLB
    assign lk.fill_vpn   = tlb_write_vaddr[addr_bits-1:page_offset_bits];
    assign lk.fill_ppn   = tlb_write_paddr[addr_bits-1:page_offset_bits];

    // supervisor accesses bypass the TLB entirely
    assign translate_ok = req_super || lk.hit;
    assign phys_addr    = req_super ? req_vaddr
                                    : {lk.ppn, req_vaddr[page_offset_bits-1:0]};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= idle;
            ack        <= 1'b0;
            err        <= 1'b0;
            ram_cyc    <= 1'b0;
            ram_stb    <= 1'b0;
            miss_pend  <= 1'b0;
            exception  <= exc_none;
            fault_addr <= '0;
        end else begin
            if (tlb_write && !supervisor) begin
                exception  <= exc_priv;
                fault_addr <= tlb_write_vaddr;
            end
            case (state)
                idle: begin
                    if (cyc && stb) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    ram_cyc   <= translate_ok;
                    ram_stb   <= translate_ok;
                    miss_pend <= !translate_ok; // reported one edge later
                    state     <= bus_cycle;
                end
                bus_cycle: begin
                    if (miss_pend) begin
                        err        <= 1'b1;
                        exception  <= exc_tlb_miss;
                        fault_addr <= req_vaddr;
                        state      <= respond;
                    end else if (ram_ack) begin
                        ack       <= 1'b1;
                        exception <= exc_none;
                        ram_cyc   <= 1'b0;
                        ram_stb   <= 1'b0;
                        state     <= respond;
                    end else if (ram_err) begin
                        err        <= 1'b1;
                        exception  <= exc_bus;
                        fault_addr <= req_vaddr;
                        ram_cyc    <= 1'b0;
                        ram_stb    <= 1'b0;
                        state      <= respond;
                    end
                end
                respond: begin
                    ack   <= 1'b0; // CPU response is a single cycle
                    err   <= 1'b0;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && cyc && stb) begin
            req_vaddr <= adr;
            req_we    <= we;
            req_dat_w <= dat_w;
            req_super <= supervisor;
        end
        if (state == lookup) begin
            ram_adr   <= phys_addr;
            ram_we    <= req_we;
            ram_dat_w <= req_dat_w;
        end
        if ((state == bus_cycle) && ram_ack) begin
            dat_r <= ram_dat_r;
        end
    end

endmodule

// ==== hdl/phys_ram.sv ====
`timescale 1ns/1ps

module phys_ram #(
    parameter int ram_words_log2 = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    output logic        err
);

    logic [31:0]               mem [2**ram_words_log2];
    logic [ram_words_log2-1:0] word_idx;
    logic                      out_of_range;
    logic                      req;

    assign word_idx     = adr[ram_words_log2+1:2];
    assign out_of_range = |adr[31:ram_words_log2+2];
    // each strobe gets one answer and the master drops stb after it
    assign req          = cyc && stb && !ack && !err;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= req && !out_of_range;
            err <= req && out_of_range;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !out_of_range) begin
            if (we) begin
                mem[word_idx] <= dat_w;
            end
            dat_r <= mem[word_idx]; // the master ignores the old word returned on a write
        end
    end

endmodule

// ==== hdl/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top #(
    parameter int tlb_entries    = 4,
    parameter int ram_words_log2 = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               supervisor,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [31:0]        adr,
    input  logic [31:0]        dat_w,
    output logic [31:0]        dat_r,
    output logic               ack,
    output logic               err,
    input  logic               tlb_write,
    input  logic [31:0]        tlb_write_vaddr,
    input  logic [31:0]        tlb_write_paddr,
    output logic [31:0]        fault_addr,
    output mmu_pkg::exc_code_t exception
);

    logic        ram_cyc;
    logic        ram_stb;
    logic        ram_we;
    logic [31:0] ram_adr;
    logic [31:0] ram_dat_w;
    logic [31:0] ram_dat_r;
    logic        ram_ack;
    logic        ram_err;

    tlb_lookup_if lk0 ();

    mmu_control ctrl0 (
        .clk             (clk),
        .reset           (reset),
        .supervisor      (supervisor),
        .cyc             (cyc),
        .stb             (stb),
        .we              (we),
        .adr             (adr),
        .dat_w           (dat_w),
        .dat_r           (dat_r),
        .ack             (ack),
        .err             (err),
        .tlb_write       (tlb_write),
        .tlb_write_vaddr (tlb_write_vaddr),
        .tlb_write_paddr (tlb_write_paddr),
        .fault_addr      (fault_addr),
        .exception       (exception),
        .lk              (lk0.ctrl),
        .ram_cyc         (ram_cyc),
        .ram_stb         (ram_stb),
        .ram_we          (ram_we),
        .ram_adr         (ram_adr),
        .ram_dat_w       (ram_dat_w),
        .ram_dat_r       (ram_dat_r),
        .ram_ack         (ram_ack),
        .ram_err         (ram_err)
    );

    tlb #(
        .tlb_entries (tlb_entries)
    ) tlb0 (
        .clk   (clk),
        .reset (reset),
        .lk    (lk0.tlb)
    );

    phys_ram #(
        .ram_words_log2 (ram_words_log2)
    ) ram0 (
        .clk   (clk),
        .reset (reset),
        .cyc   (ram_cyc),
        .stb   (ram_stb),
        .we    (ram_we),
        .adr   (ram_adr),
        .dat_w (ram_dat_w),
        .dat_r (ram_dat_r),
        .ack   (ram_ack),
        .err   (ram_err)
    );

endmodule

// ==== verification/mmu_asserts.sv ====
`timescale 1ns/1ps

module mmu_asserts (
    input logic               clk,
    input logic               reset,
    input logic               ack,
    input logic               err,
    input logic               ram_stb,
    input logic               ram_ack,
    input logic               ram_err,
    input mmu_pkg::exc_code_t exception
);
    import mmu_pkg::*;

    int unsigned failures = 0;

    assert property (@(posedge clk) disable iff (reset) !(ack && err))
        else begin
            $error("ack and err are high in the same cycle");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) (ack || err) |=> !(ack || err))
        else begin
            $error("CPU response lasted longer than one cycle");
            failures++;
        end

    // the RAM strobe stays up until the slave answers
    assert property (@(posedge clk) disable iff (reset)
                     (ram_stb && !ram_ack && !ram_err) |=> ram_stb)
        else begin
            $error("ram_stb dropped before ram_ack or ram_err");
            failures++;
        end

    assert property (@(posedge clk) $fell(reset) |-> (exception == exc_none))
        else begin
            $error("exception is not exc_none after reset");
            failures++;
        end

endmodule

bind mmu_control mmu_asserts asserts0 (
    .clk       (clk),
    .reset     (reset),
    .ack       (ack),
    .err       (err),
    .ram_stb   (ram_stb),
    .ram_ack   (ram_ack),
    .ram_err   (ram_err),
    .exception (exception)
);

// ==== verification/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int tlb_entries    = 4;
    localparam int ram_words_log2 = 10;
    localparam int n_trans        = 50; // accesses and fills in the whole run
    localparam logic [31:0] ram_mask  = (4 << ram_words_log2) - 4;
    localparam logic [31:0] page_mask = 32'hffff_f000;

    logic        clk = 1'b0;
    logic        reset;
    logic        supervisor;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        err;
    logic        tlb_write;
    logic [31:0] tlb_write_vaddr;
    logic [31:0] tlb_write_paddr;
    logic [31:0] fault_addr;
    exc_code_t   exception;

    logic [19:0]                    ref_vpn [tlb_entries];
    logic [19:0]                    ref_ppn [tlb_entries];
    logic [tlb_entries-1:0]         ref_valid;
    logic [$clog2(tlb_entries)-1:0] ref_ptr;
    logic [31:0]                    ref_mem [2**ram_words_log2];
    exc_code_t                      ref_exc;
    logic [31:0]                    ref_fault;
    logic [31:0]                    rng;
    int                             cycle = 0;
    int                             issue_cycle;
    logic                           exp_ack;
    logic                           exp_err;
    logic                           exp_read;
    logic [31:0]                    exp_dat;
    int                             exp_lat; // edges from request to response

    mmu_top #(
        .tlb_entries    (tlb_entries),
        .ram_words_log2 (ram_words_log2)
    ) dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // predicts the CPU response to one access and advances the reference state
    function automatic void predict(input logic is_super, input logic wr,
                                    input logic [31:0] a, input logic [31:0] d);
        logic        hit;
        logic [31:0] pa;
        hit      = is_super;
        pa       = a;
        exp_read = !wr;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!is_super && ref_valid[i] && (ref_vpn[i] == a[31:12])) begin
                hit = 1'b1; // a later index overrides an earlier match
                pa  = {ref_ppn[i], a[11:0]};
            end
        end
        exp_ack = hit && ((pa >> 2) < (1 << ram_words_log2));
        exp_err = !exp_ack;
        exp_lat = hit ? 4 : 3;
        if (!hit) begin
            ref_exc   = exc_tlb_miss;
            ref_fault = a;
        end else if (exp_err) begin
            ref_exc   = exc_bus;
            ref_fault = a;
        end else begin
            ref_exc = exc_none;
            if (wr) begin
                ref_mem[pa[ram_words_log2+1:2]] = d;
            end
            exp_dat = ref_mem[pa[ram_words_log2+1:2]];
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
            $display("sim failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic access(input logic is_super, input logic wr,
                          input logic [31:0] a, input logic [31:0] d);
        predict(is_super, wr, a, d);
        supervisor  = is_super;
        we          = wr;
        adr         = a;
        dat_w       = d;
        cyc         = 1'b1;
        stb         = 1'b1;
        issue_cycle = cycle;
        do begin
            @(posedge clk);
            #1;
        end while (!(ack || err));
        cyc = 1'b0;
        stb = 1'b0; // idle for one cycle between requests
        @(posedge clk);
        #1;
    endtask

    task automatic fill(input logic is_super, input logic [31:0] va, input logic [31:0] pa);
        supervisor      = is_super;
        tlb_write       = 1'b1;
        tlb_write_vaddr = va;
        tlb_write_paddr = pa;
        if (is_super) begin
            ref_vpn[ref_ptr]   = va[31:12];
            ref_ppn[ref_ptr]   = pa[31:12];
            ref_valid[ref_ptr] = 1'b1;
            ref_ptr            = ref_ptr + 1'b1;
        end else begin
            ref_exc   = exc_priv;
            ref_fault = va;
        end
        @(posedge clk);
        #1;
        tlb_write = 1'b0;
        compare("exception", 32'(exception), 32'(ref_exc));
        compare("fault_addr", fault_addr, ref_fault);
    endtask

    // checks every CPU response against the prediction made at issue time
    always begin
        @(posedge clk);
        #1;
        if (ack || err) begin
            compare("ack", 32'(ack), 32'(exp_ack));
            compare("err", 32'(err), 32'(exp_err));
            compare("latency", cycle - issue_cycle, exp_lat);
            compare("exception", 32'(exception), 32'(ref_exc));
            compare("fault_addr", fault_addr, ref_fault);
            if (ack && exp_read) begin
                compare("dat_r", dat_r, exp_dat);
            end
        end
    end

    initial begin
        #(n_trans * 20 * 8 + 2 * 8);
        $display("watchdog expired before all transactions completed");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] pages [tlb_entries];
        logic [31:0] addrs [8];
        logic [31:0] a;
        rng             = 32'ha9dc6d19;
        reset           = 1'b1;
        supervisor      = 1'b0;
        cyc             = 1'b0;
        stb             = 1'b0;
        we              = 1'b0;
        adr             = '0;
        dat_w           = '0;
        tlb_write       = 1'b0;
        tlb_write_vaddr = '0;
        tlb_write_paddr = '0;
        ref_valid       = '0;
        ref_ptr         = '0;
        ref_exc         = exc_none;
        ref_fault       = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("exception", 32'(exception), 32'(exc_none));
        compare("ack", 32'(ack), 32'd0);
        compare("err", 32'(err), 32'd0);

        repeat (4) access(1'b0, 1'b0, next_rand(), '0); // every user access misses while the TLB is empty

        for (int i = 0; i < 8; i++) begin
            addrs[i] = next_rand() & ram_mask;
            access(1'b1, 1'b1, addrs[i], next_rand());
        end
        for (int i = 0; i < 8; i++) access(1'b1, 1'b0, addrs[i], '0);

        for (int i = 0; i < tlb_entries; i++) begin
            pages[i] = next_rand() & page_mask;
            fill(1'b1, pages[i], 32'h0);
        end
        for (int i = 0; i < tlb_entries; i++) begin
            a = next_rand() & ram_mask;
            access(1'b0, 1'b1, pages[i] | a, next_rand());
            access(1'b1, 1'b0, a, '0);
            access(1'b0, 1'b0, pages[i] | a, '0);
        end

        a = next_rand() & page_mask;
        fill(1'b0, a, 32'h0);
        access(1'b0, 1'b0, a | addrs[0], '0);
        access(1'b0, 1'b0, pages[1] | addrs[0], '0);

        a = next_rand() & page_mask;
        fill(1'b1, a, 32'h0); // evicts the oldest entry
        access(1'b0, 1'b0, pages[0] | addrs[1], '0);
        access(1'b0, 1'b0, a | addrs[1], '0);
        fill(1'b1, pages[3], 32'h0000_5000);
        access(1'b0, 1'b0, pages[3] | addrs[2], '0);
        fill(1'b1, a, 32'h0000_5000);
        access(1'b0, 1'b0, a | addrs[3], '0);
        access(1'b1, 1'b1, 32'h0001_0000 | addrs[4], next_rand());

        if (dut0.ctrl0.asserts0.failures == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("bound assertions reported failures");
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/mmu_pkg.sv
hdl/tlb_lookup_if.sv
hdl/tlb.sv
hdl/mmu_control.sv
hdl/phys_ram.sv
hdl/mmu_top.sv
verification/mmu_asserts.sv
verification/mmu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := mmu_tb
FILELIST  := filelist.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
PASS_MSG  := sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
